//--- src/stream_config.svh
`ifndef STREAM_CONFIG_SVH
`define STREAM_CONFIG_SVH

// widths of the streaming path

`define STREAM_BYTE_W 8   // input byte from the producer side
`define STREAM_WORD_W 16  // packed word, also the checksum width

// word buffer geometry

`define STREAM_FIFO_DEPTH 8  // number of stored words
`define STREAM_ADDR_W     3  // log2 of the depth

// occupancy thresholds for the almost flags

`define STREAM_AFULL_LEVEL  6  // almost_full at or above this count
`define STREAM_AEMPTY_LEVEL 1  // almost_empty at or below this count

`endif

//--- src/stream_pkg.sv
`include "stream_config.svh"

package stream_pkg;

    // one input byte as it arrives from outside
    typedef logic [`STREAM_BYTE_W-1:0] byte_t;

    // a packed pair of bytes, high byte first
    // the running checksum uses the same width and wraps at 2^16
    typedef logic [`STREAM_WORD_W-1:0] word_t;

    // read and write pointers into the word buffer
    typedef logic [`STREAM_ADDR_W-1:0] fifo_ptr_t;

    // occupancy count, one bit wider than a pointer
    // so a completely full buffer can be represented
    typedef logic [`STREAM_ADDR_W:0] fifo_cnt_t;

endpackage

//--- src/byte_packer.sv
`timescale 1ns/1ps

module byte_packer
    import stream_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  byte_t in_byte,
    output logic  wr_en,
    output word_t wr_data
);

    logic  phase;    // low while waiting for the high byte of a pair
    byte_t hi_byte;  // first byte of the pair, held until its partner arrives

    // pairing state flips on every accepted byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= 1'b0;
        end else if (in_valid) begin
            phase <= ~phase;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !phase) begin
            hi_byte <= in_byte;
        end
    end

    // the write strobe lasts one cycle, set by the second byte of a pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= in_valid && phase;
        end
    end

    // payload only changes when a word is completed
    always_ff @(posedge clk) begin
        if (in_valid && phase) begin
            wr_data <= {hi_byte, in_byte};  // first byte lands in the upper half
        end
    end

endmodule

//--- src/sync_fifo.sv
`timescale 1ns/1ps
`include "stream_config.svh"

module sync_fifo
    import stream_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wr_en,
    input  word_t wr_data,
    input  logic  rd_en,
    output word_t rd_data,
    output logic  full,
    output logic  empty,
    output logic  almost_full,
    output logic  almost_empty,
    output logic  overflow
);

    localparam fifo_ptr_t LAST_PTR   = fifo_ptr_t'(`STREAM_FIFO_DEPTH - 1);
    localparam fifo_cnt_t DEPTH_CNT  = fifo_cnt_t'(`STREAM_FIFO_DEPTH);
    localparam fifo_cnt_t AFULL_CNT  = fifo_cnt_t'(`STREAM_AFULL_LEVEL);
    localparam fifo_cnt_t AEMPTY_CNT = fifo_cnt_t'(`STREAM_AEMPTY_LEVEL);

    word_t     mem [`STREAM_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    logic      wr_accept;
    logic      rd_accept;

    // a full buffer drops the write even when a pop happens in the same cycle
    assign wr_accept = wr_en && !full;
    assign rd_accept = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_accept) begin
            if (wr_ptr == LAST_PTR) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_accept) begin
            if (rd_ptr == LAST_PTR) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // a write and a pop together leave the occupancy where it was
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one cycle pulse for every write that met a full buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else begin
            overflow <= wr_en && full;
        end
    end

    assign rd_data = mem[rd_ptr];  // show-ahead, the oldest word is always visible

    assign full         = (count == DEPTH_CNT);
    assign empty        = (count == '0);
    assign almost_full  = (count >= AFULL_CNT);
    assign almost_empty = (count <= AEMPTY_CNT);

endmodule

//--- src/word_checksum.sv
`timescale 1ns/1ps

module word_checksum
    import stream_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  drain_en,
    input  logic  empty,
    input  word_t rd_data,
    output logic  rd_en,
    output logic  out_valid,
    output word_t out_word,
    output word_t out_sum
);

    // pop whenever draining is allowed and the buffer shows a word
    assign rd_en = drain_en && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;  // one pulse per popped word
        end
    end

    // running sum includes the word popped at this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_sum <= '0;
        end else if (rd_en) begin
            out_sum <= out_sum + rd_data;  // carry out of bit 15 is discarded
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            out_word <= rd_data;
        end
    end

endmodule

//--- src/stream_top.sv
`timescale 1ns/1ps

module stream_top
    import stream_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  byte_t in_byte,
    input  logic  drain_en,
    output logic  out_valid,
    output word_t out_word,
    output word_t out_sum,
    output logic  full,
    output logic  empty,
    output logic  almost_full,
    output logic  almost_empty,
    output logic  overflow
);

    logic  wr_en;    // producer strobe into the buffer
    word_t wr_data;
    logic  rd_en;    // consumer pop
    word_t rd_data;  // oldest buffered word

    // pairs bytes into words, no back-pressure from the buffer
    byte_packer u_byte_packer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_byte  (in_byte),
        .wr_en    (wr_en),
        .wr_data  (wr_data)
    );

    sync_fifo u_sync_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (overflow)
    );

    // empty goes to the consumer as well as out of the top level
    word_checksum u_word_checksum (
        .clk       (clk),
        .rst_n     (rst_n),
        .drain_en  (drain_en),
        .empty     (empty),
        .rd_data   (rd_data),
        .rd_en     (rd_en),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_sum   (out_sum)
    );

endmodule

//--- testbench/tb_stream.sv
`timescale 1ns/1ps
`include "stream_config.svh"

module tb_stream
    import stream_pkg::*;
();

    localparam int          RANDOM_CYCLES = 400;
    localparam int          DRAIN_TIMEOUT = 64;
    localparam int          MAX_VEC_READS = 1000;
    localparam int unsigned SEED          = 32'h0497_cae1;
    localparam string       VEC_FILE      = "testbench/stream_vectors.txt";

    logic  clk = 1'b0;
    logic  rst_n;
    logic  in_valid;
    byte_t in_byte;
    logic  drain_en;
    logic  out_valid;
    word_t out_word;
    word_t out_sum;
    logic  full;
    logic  empty;
    logic  almost_full;
    logic  almost_empty;
    logic  overflow;

    // reference model state, stepped once per active clock edge
    logic  m_phase;
    byte_t m_hi;
    logic  m_wr_pend;     // mirrors the registered write strobe of the packer
    word_t m_wr_word;
    word_t m_queue[$];
    word_t m_sum;
    logic  exp_valid;
    logic  exp_ovf;
    word_t exp_word;
    int    words_popped;
    int    writes_dropped;

    // inputs the DUT will sample at the next rising edge
    logic  cur_valid;
    byte_t cur_byte;
    logic  cur_drain;

    always #2 clk = ~clk;

    stream_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_byte      (in_byte),
        .drain_en     (drain_en),
        .out_valid    (out_valid),
        .out_word     (out_word),
        .out_sum      (out_sum),
        .full         (full),
        .empty        (empty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .overflow     (overflow)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one rising edge of the whole path, using the inputs sampled at that edge
    task automatic model_edge();
        logic full_pre;
        logic wr_accept;
        logic rd_accept;
        full_pre  = (m_queue.size() == `STREAM_FIFO_DEPTH);
        rd_accept = cur_drain && (m_queue.size() != 0);
        wr_accept = m_wr_pend && !full_pre;
        exp_ovf   = m_wr_pend && full_pre;  // dropped even when a pop happens too
        exp_valid = rd_accept;
        if (rd_accept) begin
            exp_word = m_queue.pop_front();
            m_sum    = m_sum + exp_word;
            words_popped++;
        end
        if (wr_accept) begin
            m_queue.push_back(m_wr_word);
        end
        if (exp_ovf) begin
            writes_dropped++;
        end
        m_wr_pend = cur_valid && m_phase;
        if (cur_valid && m_phase) begin
            m_wr_word = {m_hi, cur_byte};  // first byte of the pair is the high half
        end
        if (cur_valid && !m_phase) begin
            m_hi = cur_byte;
        end
        if (cur_valid) begin
            m_phase = !m_phase;
        end
    endtask

    task automatic check_outputs();
        int n;
        n = m_queue.size();
        check_value("out_valid", 32'(out_valid), 32'(exp_valid));
        if (exp_valid) begin
            check_value("out_word", 32'(out_word), 32'(exp_word));
        end
        check_value("out_sum", 32'(out_sum), 32'(m_sum));
        check_value("empty", 32'(empty), 32'(n == 0));
        check_value("full", 32'(full), 32'(n == `STREAM_FIFO_DEPTH));
        check_value("almost_full", 32'(almost_full), 32'(n >= `STREAM_AFULL_LEVEL));
        check_value("almost_empty", 32'(almost_empty), 32'(n <= `STREAM_AEMPTY_LEVEL));
        check_value("overflow", 32'(overflow), 32'(exp_ovf));
    endtask

    task automatic check_reset_state();
        check_value("empty", 32'(empty), 32'd1);
        check_value("almost_empty", 32'(almost_empty), 32'd1);
        check_value("full", 32'(full), 32'd0);
        check_value("almost_full", 32'(almost_full), 32'd0);
        check_value("overflow", 32'(overflow), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("out_sum", 32'(out_sum), 32'd0);
    endtask

    // drive one cycle of stimulus and compare the result after the next edge
    task automatic run_cycle(input logic v, input byte_t b, input logic d);
        @(posedge clk);
        model_edge();
        in_valid  <= v;
        in_byte   <= b;
        drain_en  <= d;
        cur_valid = v;
        cur_byte  = b;
        cur_drain = d;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic apply_vectors();
        int          fd;
        int          reads;
        int          applied;
        string       line;
        logic [31:0] v;
        logic [31:0] b;
        logic [31:0] d;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", VEC_FILE);
            $display("TESTS FAILED");
            $fatal(1, "vector file missing");
        end
        reads   = 0;
        applied = 0;
        while (!$feof(fd) && reads < MAX_VEC_READS) begin
            reads++;
            if ($fgets(line, fd) > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h", v, b, d) == 3) begin
                    run_cycle(v[0], byte_t'(b), d[0]);
                    applied++;
                end
            end
        end
        $fclose(fd);
        if (applied == 0) begin
            $display("the vector file held no stimulus lines");
            $display("TESTS FAILED");
            $fatal(1, "empty vector file");
        end
        if (writes_dropped == 0) begin
            $display("the directed vectors never pushed a word into a full FIFO");
            $display("TESTS FAILED");
            $fatal(1, "no overflow in vectors");
        end
        $display("applied %0d vector cycles", applied);
    endtask

    // traffic comes in stretches so the FIFO both fills up and runs dry
    task automatic apply_random(input int cycles);
        int    mode;
        logic  v;
        byte_t b;
        logic  d;
        mode = 0;
        for (int i = 0; i < cycles; i++) begin
            if (i % 50 == 0) begin
                mode = int'($urandom % 3);
            end
            b = byte_t'($urandom);
            case (mode)
                0: begin
                    d = 1'b0;  // fill toward full and overflow
                    v = ($urandom % 4) != 0;
                end
                1: begin
                    d = 1'b1;
                    v = ($urandom % 3) == 0;
                end
                default: begin
                    d = ($urandom % 2) != 0;
                    v = ($urandom % 2) != 0;
                end
            endcase
            run_cycle(v, b, d);
        end
    endtask

    task automatic drain_to_empty();
        int waited;
        waited = 0;
        run_cycle(1'b0, '0, 1'b1);
        while ((!empty || m_wr_pend) && waited < DRAIN_TIMEOUT) begin
            run_cycle(1'b0, '0, 1'b1);
            waited++;
        end
        if (!empty || m_wr_pend) begin
            $display("the FIFO never drained within %0d cycles", DRAIN_TIMEOUT);
            $display("TESTS FAILED");
            $fatal(1, "drain timeout");
        end
        run_cycle(1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, 1'b1);
    endtask

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_byte        = '0;
        drain_en       = 1'b0;
        cur_valid      = 1'b0;
        cur_byte       = '0;
        cur_drain      = 1'b0;
        m_phase        = 1'b0;
        m_hi           = '0;
        m_wr_pend      = 1'b0;
        m_wr_word      = '0;
        m_sum          = '0;
        exp_valid      = 1'b0;
        exp_ovf        = 1'b0;
        exp_word       = '0;
        words_popped   = 0;
        writes_dropped = 0;
        void'($urandom(SEED));

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        rst_n <= 1'b1;  // released at the fifth edge

        apply_vectors();
        apply_random(RANDOM_CYCLES);
        drain_to_empty();

        $display("checked %0d words, %0d dropped writes", words_popped, writes_dropped);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- testbench/stream_vectors.txt
# columns: in_valid in_byte drain_en, all hex, one line per clock cycle
# drain_en low stretches push the FIFO past full, high stretches drain it
0 00 1
0 00 1
1 a5 1
1 3c 1
0 00 1
0 00 1
0 00 1
1 12 1
1 34 1
1 56 1
1 78 1
0 00 1
0 00 1
1 01 0
1 02 0
1 03 0
1 04 0
1 05 0
1 06 0
1 07 0
1 08 0
1 09 0
1 0a 0
1 0b 0
1 0c 0
1 0d 0
1 0e 0
1 0f 0
1 10 0
1 11 0
1 12 0
1 13 0
1 14 0
0 00 0
0 00 0
1 e1 0
1 e2 0
0 00 1
0 00 0
1 f1 0
1 f2 0
0 00 0
0 00 0
1 c1 1
1 c2 1
1 c3 1
1 c4 1
0 00 1
1 ff 1
1 ff 1
1 ff 1
1 ff 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1
0 00 1

//--- tb.f
+incdir+src
src/stream_pkg.sv
src/byte_packer.sv
src/sync_fifo.sv
src/word_checksum.sv
src/stream_top.sv
testbench/tb_stream.sv

//--- Makefile
# Verilator build and run of the stream testbench

VERILATOR ?= verilator
TOP       ?= tb_stream
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
